// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := tb_top
FILELIST := compile.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
+incdir+include
verilog/snake_pkg.sv
verilog/sync_fifo.sv
verilog/board_map.sv
verilog/frame_tracker.sv
verilog/scan_ctrl.sv
verilog/snake_display_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== include/snake_macros.svh ====
`ifndef SNAKE_MACROS_SVH
`define SNAKE_MACROS_SVH

// board size in cells.
`define SNAKE_GRID_W 16
`define SNAKE_GRID_H 12

// one coordinate covers the wider of the two board axes.
`define SNAKE_COORD_W 4

// command queue from the host.
`define SNAKE_CMD_DEPTH 4
// update queue towards the display writer.
`define SNAKE_UPD_DEPTH 8

`endif

// ==== tb/tb_checker.sv ====
`timescale 1ns/100ps
`include "snake_macros.svh"

module tb_checker (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    cmd_valid,
    input  logic                    cmd_ready,
    input  snake_pkg::cell_cmd_t    cmd,
    input  logic                    cfg_valid,
    input  snake_pkg::scan_cfg_t    cfg,
    input  logic                    out_valid,
    input  logic                    out_ready,
    input  snake_pkg::cell_update_t out_upd,
    input  logic [7:0]              frame_count,
    input  logic                    check_req,  // close one check window.
    input  logic [7:0]              exp_upd,    // updates expected in the window.
    input  logic [7:0]              exp_frames,
    output int                      err_count
);

    import snake_pkg::*;

    localparam int GRID_W = `SNAKE_GRID_W;
    localparam int GRID_H = `SNAKE_GRID_H;

    obj_code_t board [GRID_W][GRID_H]; // model of the host contents.
    obj_code_t shown [GRID_W][GRID_H]; // model of what the display holds.
    logic      border_on;
    logic      pend_valid;              // command accepted at the last edge.
    cell_cmd_t pend_cmd;
    int        upd_seen;
    int        last_idx;                // raster index of the last update.
    int        ux;
    int        uy;

    // border wins over the stored content.
    function automatic obj_code_t expect_code(int x, int y);
        if (border_on && (x == 0 || x == GRID_W - 1 || y == 0 || y == GRID_H - 1)) begin
            return border_c;
        end
        return board[x][y];
    endfunction

    always @(posedge clk) begin
        if (!nrst) begin
            for (int i = 0; i < GRID_W; i++) begin
                for (int j = 0; j < GRID_H; j++) begin
                    board[i][j] = blank;
                    shown[i][j] = blank; // display starts empty.
                end
            end
            border_on  = 1'b0;
            pend_valid = 1'b0;
            upd_seen   = 0;
            last_idx   = -1;
            err_count  = 0;
        end else begin
            if (out_valid && out_ready) begin // one record taken by the display.
                ux = int'(out_upd.x);
                uy = int'(out_upd.y);
                if (uy >= GRID_H) begin
                    $display("Update addresses row %0d, which lies off the board", uy);
                    err_count++;
                end else begin
                    if (uy * GRID_W + ux <= last_idx) begin
                        $display("Update for cell (%0d,%0d) breaks raster order", ux, uy);
                        err_count++;
                    end
                    if (out_upd.old_obj != shown[ux][uy]) begin
                        $display("Mismatch out_upd.old_obj at (%0d,%0d): expected %h, actual %h",
                                 ux, uy, shown[ux][uy], out_upd.old_obj);
                        err_count++;
                    end
                    if (out_upd.new_obj != expect_code(ux, uy)) begin
                        $display("Mismatch out_upd.new_obj at (%0d,%0d): expected %h, actual %h",
                                 ux, uy, expect_code(ux, uy), out_upd.new_obj);
                        err_count++;
                    end
                    if (out_upd.old_obj == out_upd.new_obj) begin
                        $display("Update for cell (%0d,%0d) carries no change", ux, uy);
                        err_count++;
                    end
                    shown[ux][uy] = expect_code(ux, uy); // display now holds the model value.
                    last_idx      = uy * GRID_W + ux;
                    upd_seen++;
                end
            end
            // the board map writes one clock after the queue accepts.
            if (pend_valid && int'(pend_cmd.y) < GRID_H) begin
                board[pend_cmd.x][pend_cmd.y] = pend_cmd.obj;
            end
            pend_valid = cmd_valid & cmd_ready;
            pend_cmd   = cmd;
            if (cfg_valid) begin
                border_on = cfg.border_en;
            end
            if (check_req) begin
                if (upd_seen != int'(exp_upd)) begin
                    $display("Mismatch update count: expected %h, actual %h", exp_upd, upd_seen);
                    err_count++;
                end
                if (frame_count != exp_frames) begin
                    $display("Mismatch frame_count: expected %h, actual %h",
                             exp_frames, frame_count);
                    err_count++;
                end
                for (int i = 0; i < GRID_W; i++) begin
                    for (int j = 0; j < GRID_H; j++) begin
                        if (shown[i][j] != expect_code(i, j)) begin
                            $display("Update for cell (%0d,%0d) never arrived", i, j);
                            err_count++;
                        end
                    end
                end
                upd_seen = 0;
                last_idx = -1; // next window starts a new frame.
            end
        end
    end

endmodule

// ==== tb/tb_top.sv ====
`timescale 1ns/100ps
`include "snake_macros.svh"

module tb_top;

    import snake_pkg::*;

    localparam int FRAME_TIMEOUT = 3000; // clean frame takes 192 cycles.
    localparam int HS_TIMEOUT    = 200;

    typedef enum logic [1:0] {k_cmd, k_cfg, k_wait, k_idle} step_kind_t;

    typedef struct packed {
        step_kind_t  kind;
        cell_cmd_t   cmd;
        scan_cfg_t   cfg;
        logic [15:0] num;     // frame count to reach, or idle cycles.
        logic [7:0]  exp_upd; // updates since the previous check.
    } step_t;

    logic         clk;
    logic         nrst;
    logic         cmd_valid;
    logic         cmd_ready;
    cell_cmd_t    cmd;
    logic         cfg_valid;
    scan_cfg_t    cfg;
    logic         out_valid;
    logic         out_ready;
    cell_update_t out_upd;
    logic [7:0]   frame_count;
    logic         check_req;
    logic [7:0]   exp_upd;
    logic [7:0]   exp_frames;
    int           err_count;
    int           timeouts;
    bit           ok;
    step_t        steps [$];

    snake_display_top UUT (
        .clk (clk), .nrst (nrst),
        .cmd_valid (cmd_valid), .cmd_ready (cmd_ready), .cmd (cmd),
        .cfg_valid (cfg_valid), .cfg (cfg),
        .out_valid (out_valid), .out_ready (out_ready), .out_upd (out_upd),
        .frame_count (frame_count)
    );

    tb_checker u_checker (
        .clk (clk), .nrst (nrst),
        .cmd_valid (cmd_valid), .cmd_ready (cmd_ready), .cmd (cmd),
        .cfg_valid (cfg_valid), .cfg (cfg),
        .out_valid (out_valid), .out_ready (out_ready), .out_upd (out_upd),
        .frame_count (frame_count), .check_req (check_req),
        .exp_upd (exp_upd), .exp_frames (exp_frames), .err_count (err_count)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk; // 10 ns period.

    // display writer stalls about one cycle in three.
    initial begin
        void'($urandom(32'h92ba_40d3));
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            out_ready <= ($urandom % 3) != 0;
        end
    end

    function automatic step_t mk(step_kind_t kind, logic [10:0] cmd_bits,
                                 logic [2:0] cfg_bits, int num, int exp);
        step_t s;
        s         = '0;
        s.kind    = kind;
        s.cmd     = cmd_bits;
        s.cfg     = cfg_bits; // {run, step, border_en}.
        s.num     = 16'(num);
        s.exp_upd = 8'(exp);
        return s;
    endfunction

    task automatic apply_step(input step_t s);
        int n;
        n = 0;
        @(posedge clk);
        case (s.kind)
            k_cmd: begin
                cmd_valid <= 1'b1;
                cmd       <= s.cmd;
                while (1) begin
                    @(posedge clk);
                    if (cmd_ready) break; // beat taken at this edge.
                    n++;
                    if (n > HS_TIMEOUT) begin
                        $display("Timeout: command queue never accepted a cell write");
                        timeouts++;
                        ok = 1'b0;
                        break;
                    end
                end
                cmd_valid <= 1'b0;
            end
            k_cfg: begin
                cfg_valid <= 1'b1;
                cfg       <= s.cfg;
                @(posedge clk);
                cfg_valid <= 1'b0;
            end
            k_idle: repeat (int'(s.num)) @(posedge clk);
            default: begin
                while (frame_count < s.num[7:0]) begin
                    @(posedge clk);
                    n++;
                    if (n > FRAME_TIMEOUT) begin
                        $display("Timeout: frame count never reached %0d", s.num);
                        timeouts++;
                        ok = 1'b0;
                        return;
                    end
                end
                n = 0;
                while (out_valid) begin // let the update queue drain.
                    @(posedge clk);
                    n++;
                    if (n > FRAME_TIMEOUT) begin
                        $display("Timeout: update queue never drained");
                        timeouts++;
                        ok = 1'b0;
                        return;
                    end
                end
                check_req  <= 1'b1;
                exp_upd    <= s.exp_upd;
                exp_frames <= s.num[7:0];
                @(posedge clk);
                check_req  <= 1'b0;
            end
        endcase
    endtask

    initial begin
        nrst       = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        cfg_valid  = 1'b0;
        cfg        = '0;
        check_req  = 1'b0;
        exp_upd    = '0;
        exp_frames = '0;
        timeouts   = 0;
        ok         = 1'b1;
        steps.push_back(mk(k_idle, 0, 3'b000, 40, 0));                     // quiet after reset.
        steps.push_back(mk(k_wait, 0, 3'b000, 0, 0));
        steps.push_back(mk(k_cfg, 0, 3'b011, 0, 0));                       // one frame, border.
        steps.push_back(mk(k_wait, 0, 3'b000, 1, 52));
        steps.push_back(mk(k_idle, 0, 3'b000, 300, 0));                    // must stay stopped.
        steps.push_back(mk(k_wait, 0, 3'b000, 1, 0));
        steps.push_back(mk(k_cmd, {4'd5, 4'd5, snake_head}, 3'b000, 0, 0));
        steps.push_back(mk(k_cmd, {4'd6, 4'd5, snake_body}, 3'b000, 0, 0));
        steps.push_back(mk(k_cmd, {4'd9, 4'd7, apple_c}, 3'b000, 0, 0));
        steps.push_back(mk(k_cfg, 0, 3'b011, 0, 0));
        steps.push_back(mk(k_wait, 0, 3'b000, 2, 3));
        steps.push_back(mk(k_cfg, 0, 3'b011, 0, 0));                       // nothing changed.
        steps.push_back(mk(k_wait, 0, 3'b000, 3, 0));
        steps.push_back(mk(k_cmd, {4'd0, 4'd4, apple_c}, 3'b000, 0, 0));  // hidden by border.
        steps.push_back(mk(k_cfg, 0, 3'b011, 0, 0));
        steps.push_back(mk(k_wait, 0, 3'b000, 4, 0));
        steps.push_back(mk(k_cfg, 0, 3'b010, 0, 0));                       // border off.
        steps.push_back(mk(k_wait, 0, 3'b000, 5, 52));
        steps.push_back(mk(k_cmd, {4'd0, 4'd4, blank}, 3'b000, 0, 0));
        steps.push_back(mk(k_cfg, 0, 3'b010, 0, 0));
        steps.push_back(mk(k_wait, 0, 3'b000, 6, 1));
        steps.push_back(mk(k_cmd, {4'd1, 4'd1, snake_body}, 3'b000, 0, 0));
        steps.push_back(mk(k_cmd, {4'd2, 4'd1, snake_body}, 3'b000, 0, 0));
        steps.push_back(mk(k_cmd, {4'd3, 4'd1, snake_head}, 3'b000, 0, 0));
        steps.push_back(mk(k_cmd, {4'd14, 4'd10, apple_c}, 3'b000, 0, 0));
        steps.push_back(mk(k_cfg, 0, 3'b011, 0, 0));                       // dense frame.
        steps.push_back(mk(k_wait, 0, 3'b000, 7, 56));
        steps.push_back(mk(k_cfg, 0, 3'b101, 0, 0));                       // run mode.
        steps.push_back(mk(k_wait, 0, 3'b000, 8, 0));
        steps.push_back(mk(k_cmd, {4'd7, 4'd9, snake_head}, 3'b000, 0, 0)); // ahead of scan.
        steps.push_back(mk(k_wait, 0, 3'b000, 9, 1));
        steps.push_back(mk(k_cmd, {4'd7, 4'd9, snake_body}, 3'b000, 0, 0));
        steps.push_back(mk(k_cmd, {4'd12, 4'd9, apple_c}, 3'b000, 0, 0));
        steps.push_back(mk(k_wait, 0, 3'b000, 10, 2));
        steps.push_back(mk(k_wait, 0, 3'b000, 11, 0));
        steps.push_back(mk(k_cfg, 0, 3'b001, 0, 0));                       // stop, keep border.
        steps.push_back(mk(k_idle, 0, 3'b000, 400, 0));
        steps.push_back(mk(k_wait, 0, 3'b000, 11, 0));
        repeat (8) @(posedge clk);
        nrst <= 1'b1;
        for (int i = 0; i < steps.size() && ok; i++) begin
            apply_step(steps[i]);
        end
        repeat (2) @(posedge clk);
        $display("Errors: %0d in checks, %0d timeouts", err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/board_map.sv ====
`timescale 1ns/100ps
`include "snake_macros.svh"

module board_map (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      wr_valid,
    input  snake_pkg::cell_cmd_t      wr_cmd,
    input  logic                      border_en,
    input  logic [`SNAKE_COORD_W-1:0] scan_x,
    input  logic [`SNAKE_COORD_W-1:0] scan_y,
    output snake_pkg::cell_class_t    cell_class
);

    import snake_pkg::*;

    localparam int COORD_W = `SNAKE_COORD_W;
    localparam int GRID_W  = `SNAKE_GRID_W;
    localparam int GRID_H  = `SNAKE_GRID_H;
    localparam logic [COORD_W-1:0] X_LAST = COORD_W'(GRID_W - 1);
    localparam logic [COORD_W-1:0] Y_LAST = COORD_W'(GRID_H - 1);

    logic [1:0] cells [GRID_W][GRID_H]; // host contents, codes 0 to 3.
    logic       wr_in_board;
    logic       rd_in_board;
    logic       on_edge;
    obj_code_t  stored_obj;

    // x spans the full coordinate range, only y can fall off the board.
    assign wr_in_board = (wr_cmd.y <= Y_LAST);
    assign rd_in_board = (scan_y <= Y_LAST);

    // host writes, one per clock.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < GRID_W; i++) begin
                for (int j = 0; j < GRID_H; j++) begin
                    cells[i][j] <= 2'd0; // whole board blank.
                end
            end
        end else if (wr_valid && wr_in_board) begin
            cells[wr_cmd.x][wr_cmd.y] <= wr_cmd.obj[1:0];
        end
    end

    // lookup of the scanned cell.
    always_comb begin
        if (rd_in_board) begin
            stored_obj = obj_code_t'({1'b0, cells[scan_x][scan_y]});
        end else begin
            stored_obj = blank; // off board reads as empty.
        end
    end

    assign on_edge = (scan_x == '0) || (scan_x == X_LAST) ||
                     (scan_y == '0) || (scan_y == Y_LAST);

    // flags only, priority is left to the tracker.
    assign cell_class.border = border_en & on_edge;
    assign cell_class.head   = (stored_obj == snake_head);
    assign cell_class.body   = (stored_obj == snake_body);
    assign cell_class.apple  = (stored_obj == apple_c);

endmodule

// ==== verilog/frame_tracker.sv ====
`timescale 1ns/100ps
`include "snake_macros.svh"

module frame_tracker (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      scan_en,
    input  snake_pkg::cell_class_t    cell_class,
    output logic [`SNAKE_COORD_W-1:0] scan_x,
    output logic [`SNAKE_COORD_W-1:0] scan_y,
    output logic                      upd_valid,
    input  logic                      upd_ready,
    output snake_pkg::cell_update_t   upd,
    output logic                      frame_done
);

    import snake_pkg::*;

    localparam int COORD_W = `SNAKE_COORD_W;
    localparam int GRID_W  = `SNAKE_GRID_W;
    localparam int GRID_H  = `SNAKE_GRID_H;
    localparam logic [COORD_W-1:0] X_LAST = COORD_W'(GRID_W - 1);
    localparam logic [COORD_W-1:0] Y_LAST = COORD_W'(GRID_H - 1);

    obj_code_t shown [GRID_W][GRID_H]; // what the display shows now.
    obj_code_t new_obj;                // resolved code of the board cell.
    obj_code_t cur_obj;                // shown code at the scan position.
    logic      differ;
    logic      advance;
    logic      last_col;
    logic      last_cell;

    // border wins, then head, body, apple.
    always_comb begin
        if (cell_class.border) begin
            new_obj = border_c;
        end else if (cell_class.head) begin
            new_obj = snake_head;
        end else if (cell_class.body) begin
            new_obj = snake_body;
        end else if (cell_class.apple) begin
            new_obj = apple_c;
        end else begin
            new_obj = blank;
        end
    end

    assign cur_obj = shown[scan_x][scan_y];
    assign differ  = (new_obj != cur_obj);

    // a change must be taken by the queue before the scan moves on.
    assign upd_valid = scan_en & differ;
    assign advance   = scan_en & (~differ | upd_ready);

    assign last_col   = (scan_x == X_LAST);
    assign last_cell  = last_col & (scan_y == Y_LAST);
    assign frame_done = advance & last_cell; // wrap to (0,0).

    assign upd = '{x: scan_x, y: scan_y, old_obj: cur_obj, new_obj: new_obj};

    // raster position.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            scan_x <= '0;
            scan_y <= '0;
        end else if (advance) begin
            if (last_col) begin
                scan_x <= '0;
                scan_y <= last_cell ? '0 : scan_y + 1'b1; // next row or top.
            end else begin
                scan_x <= scan_x + 1'b1;
            end
        end
    end

    // shown frame follows every examined cell.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < GRID_W; i++) begin
                for (int j = 0; j < GRID_H; j++) begin
                    shown[i][j] <= blank;
                end
            end
        end else if (advance) begin
            shown[scan_x][scan_y] <= new_obj; // same value when unchanged.
        end
    end

endmodule

// ==== verilog/scan_ctrl.sv ====
`timescale 1ns/100ps

module scan_ctrl (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 cfg_valid,
    input  snake_pkg::scan_cfg_t cfg,
    input  logic                 frame_done,
    output logic                 scan_en,
    output logic                 border_en,
    output logic [7:0]           frame_count
);

    import snake_pkg::*;

    scan_cfg_t mode; // current run, step and border settings.

    // mode register.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            mode <= '0; // stopped, border off.
        end else if (cfg_valid) begin
            mode <= cfg; // host write wins over frame end.
        end else if (frame_done) begin
            mode.step <= 1'b0; // single frame is over.
        end
    end

    // completed frames, wraps at 255.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            frame_count <= 8'd0;
        end else if (frame_done) begin
            frame_count <= frame_count + 8'd1;
        end
    end

    assign scan_en   = mode.run | mode.step;
    assign border_en = mode.border_en;

endmodule

// ==== verilog/snake_display_top.sv ====
`timescale 1ns/100ps
`include "snake_macros.svh"

module snake_display_top (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  snake_pkg::cell_cmd_t    cmd,
    input  logic                    cfg_valid,
    input  snake_pkg::scan_cfg_t    cfg,
    output logic                    out_valid,
    input  logic                    out_ready,
    output snake_pkg::cell_update_t out_upd,
    output logic [7:0]              frame_count
);

    import snake_pkg::*;

    cell_cmd_t                 cmd_q;       // command at the queue head.
    logic                      cmd_q_valid;
    cell_class_t               cell_class;
    logic [`SNAKE_COORD_W-1:0] scan_x;
    logic [`SNAKE_COORD_W-1:0] scan_y;
    logic                      scan_en;
    logic                      border_en;
    logic                      frame_done;
    logic                      upd_valid;
    logic                      upd_ready;
    cell_update_t              upd;

    // host commands, drained one per clock.
    sync_fifo #(
        .payload_t (cell_cmd_t),
        .DEPTH     (`SNAKE_CMD_DEPTH)
    ) u_cmd_fifo (
        .clk       (clk),
        .nrst      (nrst),
        .in_valid  (cmd_valid),
        .in_ready  (cmd_ready),
        .in_data   (cmd),
        .out_valid (cmd_q_valid),
        .out_ready (1'b1), // board map never stalls.
        .out_data  (cmd_q)
    );

    board_map u_board_map (
        .clk        (clk),
        .nrst       (nrst),
        .wr_valid   (cmd_q_valid),
        .wr_cmd     (cmd_q),
        .border_en  (border_en),
        .scan_x     (scan_x),
        .scan_y     (scan_y),
        .cell_class (cell_class)
    );

    scan_ctrl u_scan_ctrl (
        .clk         (clk),
        .nrst        (nrst),
        .cfg_valid   (cfg_valid),
        .cfg         (cfg),
        .frame_done  (frame_done),
        .scan_en     (scan_en),
        .border_en   (border_en),
        .frame_count (frame_count)
    );

    frame_tracker u_frame_tracker (
        .clk        (clk),
        .nrst       (nrst),
        .scan_en    (scan_en),
        .cell_class (cell_class),
        .scan_x     (scan_x),
        .scan_y     (scan_y),
        .upd_valid  (upd_valid),
        .upd_ready  (upd_ready),
        .upd        (upd),
        .frame_done (frame_done)
    );

    // change records to the display writer.
    sync_fifo #(
        .payload_t (cell_update_t),
        .DEPTH     (`SNAKE_UPD_DEPTH)
    ) u_upd_fifo (
        .clk       (clk),
        .nrst      (nrst),
        .in_valid  (upd_valid),
        .in_ready  (upd_ready),
        .in_data   (upd),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_upd)
    );

endmodule

// ==== verilog/snake_pkg.sv ====
`include "snake_macros.svh"

package snake_pkg;

    // object codes as seen by the display.
    typedef enum logic [2:0] {
        blank      = 3'd0,
        snake_head = 3'd1,
        snake_body = 3'd2,
        apple_c    = 3'd3,
        border_c   = 3'd4
    } obj_code_t;

    // classification flags of one cell.
    typedef struct packed {
        logic border; // edge cell with border enabled.
        logic head;
        logic body;
        logic apple;
    } cell_class_t;

    // host write of one cell, obj only uses codes 0 to 3.
    typedef struct packed {
        logic [`SNAKE_COORD_W-1:0] x;
        logic [`SNAKE_COORD_W-1:0] y;
        obj_code_t                 obj;
    } cell_cmd_t;

    // change record sent to the display writer.
    typedef struct packed {
        logic [`SNAKE_COORD_W-1:0] x;
        logic [`SNAKE_COORD_W-1:0] y;
        obj_code_t                 old_obj; // what the display showed.
        obj_code_t                 new_obj; // what it must show now.
    } cell_update_t;

    // scan mode and border control.
    typedef struct packed {
        logic run;       // scan continuously.
        logic step;      // scan one frame then stop.
        logic border_en;
    } scan_cfg_t;

endpackage

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     nrst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    payload_t         mem [DEPTH]; // circular storage.
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;       // occupancy.
    logic             full;
    logic             push;
    logic             pop;

    assign full      = (count == CNT_FULL);
    assign in_ready  = ~full | out_ready; // a pop frees a slot in the same cycle.
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];       // head of queue.
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;

    // payload write.
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0; // empty after reset.
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1; // wrap at depth.
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or push with pop.
            endcase
        end
    end

endmodule
